// ==== Makefile ====
# Verilator build and run of the camera front testbench

SRCS := $(shell grep -v '^+' verilog.f)

.PHONY: run clean

run: obj_dir/Vcamera_front_tb verif/camera_front_testdata.txt
	./obj_dir/Vcamera_front_tb | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null

obj_dir/Vcamera_front_tb: verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module camera_front_tb -o Vcamera_front_tb

clean:
	rm -rf obj_dir

// ==== logic/camera_front_top.sv ====
`timescale 1ns/100ps

module camera_front_top #(
    parameter int data_width = pixel_stream_pkg::pixel_width_default
) (
    input  logic                          clk,
    input  logic                          resetb,
    input  logic                          fv,
    input  logic                          lv,
    input  logic [data_width-1:0]         pix,
    input  logic                          test_en,
    input  logic [data_width-1:0]         test_data,
    input  logic                          en,
    input  logic signed [data_width-1:0]  threshold_upper,
    input  logic signed [data_width-1:0]  threshold_lower,
    output pixel_stream_pkg::stream_tag_t out_tag,
    output logic [data_width-1:0]         out_data,
    output logic [15:0]                   filter_count
);
    import pixel_stream_pkg::*;

    stream_tag_t           raw_tag;
    logic [data_width-1:0] raw_data;

    // Sensor levels to tagged words
    stream_framer #(
        .data_width (data_width)
    ) framer0 (
        .clk       (clk),
        .resetb    (resetb),
        .fv        (fv),
        .lv        (lv),
        .pix       (pix),
        .test_en   (test_en),
        .test_data (test_data),
        .raw_tag   (raw_tag),
        .raw_data  (raw_data)
    );

    defect_filter #(
        .data_width (data_width)
    ) filter0 (
        .clk             (clk),
        .resetb          (resetb),
        .en              (en),
        .threshold_upper (threshold_upper),
        .threshold_lower (threshold_lower),
        .raw_tag         (raw_tag),
        .raw_data        (raw_data),
        .out_tag         (out_tag),
        .out_data        (out_data),
        .filter_count    (filter_count)
    );

endmodule

// ==== logic/defect_filter.sv ====
`timescale 1ns/100ps

module defect_filter #(
    parameter int data_width = pixel_stream_pkg::pixel_width_default
) (
    input  logic                          clk,
    input  logic                          resetb,
    input  logic                          en,
    input  logic signed [data_width-1:0]  threshold_upper,
    input  logic signed [data_width-1:0]  threshold_lower,
    input  pixel_stream_pkg::stream_tag_t raw_tag,
    input  logic [data_width-1:0]         raw_data,
    output pixel_stream_pkg::stream_tag_t out_tag,
    output logic [data_width-1:0]         out_data,
    output logic [15:0]                   filter_count
);
    import pixel_stream_pkg::*;

    typedef enum logic [1:0] {
        pass_all,
        in_row,
        row_close
    } state_t;

    state_t                state;
    logic [1:0]            pix_idx; // Saturates at 2 once both neighbours are known
    logic [15:0]           count_cur;
    logic [data_width-1:0] pix_s;   // Middle tap, the pixel about to leave
    logic [data_width-1:0] pix_ss;  // Left tap
    logic [data_width-1:0] row_num;

    logic signed [data_width+1:0] diff_r;
    logic signed [data_width+1:0] diff_l;
    logic signed [data_width+1:0] up_ext;
    logic signed [data_width+1:0] lo_ext;
    logic [data_width:0]          pair_sum;
    logic [data_width-1:0]        pair_avg;
    logic                         hot;
    logic                         dead;
    logic                         defect;

    wire is_fs = raw_tag.dv && raw_tag.wtype == wt_frame_start;
    wire is_fe = raw_tag.dv && raw_tag.wtype == wt_frame_end;
    wire is_rs = raw_tag.dv && raw_tag.wtype == wt_row_start;
    wire is_px = raw_tag.dv && raw_tag.wtype == wt_pixel;
    wire is_re = raw_tag.dv && raw_tag.wtype == wt_row_end;

    // Two extra bits keep the unsigned pixel differences and the negated threshold exact
    assign diff_r = $signed({2'b00, pix_s}) - $signed({2'b00, raw_data});
    assign diff_l = $signed({2'b00, pix_s}) - $signed({2'b00, pix_ss});
    assign up_ext = threshold_upper;
    assign lo_ext = threshold_lower;

    assign hot    = (diff_r > up_ext) && (diff_l > up_ext);
    assign dead   = (diff_r < -lo_ext) && (diff_l < -lo_ext);
    assign defect = hot | dead;

    assign pair_sum = {1'b0, pix_ss} + {1'b0, raw_data};
    assign pair_avg = pair_sum[data_width:1]; // Floor of the neighbours' mean

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            state        <= pass_all;
            pix_idx      <= 2'd0;
            count_cur    <= '0;
            filter_count <= '0;
            out_tag      <= '{dv: 1'b0, wtype: wt_frame_start};
        end else begin
            case (state)
                pass_all: begin
                    if (is_rs) begin
                        // Row start is held back until the first pixel arrives
                        out_tag.dv <= 1'b0;
                        pix_idx    <= 2'd0;
                        state      <= in_row;
                    end else begin
                        out_tag <= raw_tag;
                        if (is_fs) count_cur <= '0;
                        if (is_fe) filter_count <= count_cur;
                    end
                end
                in_row: begin
                    if (is_px) begin
                        out_tag.dv    <= 1'b1;
                        out_tag.wtype <= (pix_idx == 2'd0) ? wt_row_start : wt_pixel;
                        if (pix_idx != 2'd2) pix_idx <= pix_idx + 1'b1;
                        if (pix_idx == 2'd2 && defect) count_cur <= count_cur + 1'b1;
                    end else if (is_re) begin
                        out_tag <= '{dv: 1'b1, wtype: wt_pixel};
                        state   <= row_close;
                    end else begin
                        out_tag.dv <= 1'b0;
                    end
                end
                row_close: begin
                    out_tag <= '{dv: 1'b1, wtype: wt_row_end};
                    state   <= pass_all;
                end
                default: state <= pass_all;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            pass_all: begin
                if (is_rs) row_num <= raw_data;
                else out_data <= raw_data;
            end
            in_row: begin
                if (is_px) begin
                    pix_s  <= raw_data;
                    pix_ss <= pix_s;
                    case (pix_idx)
                        2'd0:    out_data <= row_num;
                        2'd1:    out_data <= pix_s; // First pixel of the row has no left tap
                        default: out_data <= (en && defect) ? pair_avg : pix_s;
                    endcase
                end else if (is_re) begin
                    out_data <= pix_s; // Last pixel has no right tap
                end
            end
            default: out_data <= row_num;
        endcase
    end

endmodule

// ==== logic/pixel_stream_pkg.sv ====
package pixel_stream_pkg;

    // Default pixel width of the pipeline
    parameter int pixel_width_default = 16;

    // Kind of word carried on the stream, the data bus beside it changes meaning with it
    typedef enum logic [2:0] {
        wt_frame_start = 3'd0, // Data is the frame number
        wt_row_start   = 3'd1, // Data is the row number within the frame
        wt_pixel       = 3'd2, // Data is one pixel value
        wt_row_end     = 3'd3, // Data is the row number
        wt_frame_end   = 3'd4  // Data is the number of rows in the frame
    } word_type_t;

    // Tag that travels with every stream word
    // The data bus is kept apart since its width is a module parameter
    typedef struct packed {
        logic       dv;    // Word valid, no handshake
        word_type_t wtype;
    } stream_tag_t;

endpackage

// ==== logic/stream_framer.sv ====
`timescale 1ns/100ps

module stream_framer #(
    parameter int data_width = pixel_stream_pkg::pixel_width_default
) (
    input  logic                          clk,
    input  logic                          resetb,
    input  logic                          fv,
    input  logic                          lv,
    input  logic [data_width-1:0]         pix,
    input  logic                          test_en,
    input  logic [data_width-1:0]         test_data,
    output pixel_stream_pkg::stream_tag_t raw_tag,
    output logic [data_width-1:0]         raw_data
);
    import pixel_stream_pkg::*;

    typedef enum logic [1:0] {
        idle,
        in_frame,
        in_row,
        row_close
    } state_t;

    state_t                state;
    logic                  fv_d;
    logic                  lv_d;
    logic [data_width-1:0] frame_cnt;
    logic [data_width-1:0] row_cnt;
    logic [data_width-1:0] held_pix; // One pixel of delay so the row end can follow the last pixel
    logic [data_width-1:0] pix_sel;

    wire fv_rise = fv & ~fv_d;
    wire fv_fall = ~fv & fv_d;
    wire lv_rise = lv & ~lv_d;
    wire lv_fall = ~lv & lv_d;

    assign pix_sel = test_en ? test_data : pix; // Test pattern replaces every sensor pixel

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            state     <= idle;
            fv_d      <= 1'b0;
            lv_d      <= 1'b0;
            frame_cnt <= '0;
            row_cnt   <= '0;
            raw_tag   <= '{dv: 1'b0, wtype: wt_frame_start};
        end else begin
            fv_d       <= fv;
            lv_d       <= lv;
            raw_tag.dv <= 1'b0;
            case (state)
                idle: begin
                    if (fv_rise) begin
                        raw_tag <= '{dv: 1'b1, wtype: wt_frame_start};
                        row_cnt <= '0;
                        state   <= in_frame;
                    end
                end
                in_frame: begin
                    if (fv_fall) begin
                        raw_tag   <= '{dv: 1'b1, wtype: wt_frame_end};
                        frame_cnt <= frame_cnt + 1'b1;
                        state     <= idle;
                    end else if (lv_rise) begin
                        raw_tag <= '{dv: 1'b1, wtype: wt_row_start};
                        state   <= in_row;
                    end
                end
                in_row: begin
                    // The held pixel goes out on every cycle here, also on the lv fall
                    raw_tag <= '{dv: 1'b1, wtype: wt_pixel};
                    if (lv_fall) state <= row_close;
                end
                row_close: begin
                    raw_tag <= '{dv: 1'b1, wtype: wt_row_end};
                    row_cnt <= row_cnt + 1'b1;
                    state   <= in_frame;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            idle: raw_data <= frame_cnt;
            in_frame: begin
                raw_data <= row_cnt;
                if (lv_rise) held_pix <= pix_sel;
            end
            in_row: begin
                raw_data <= held_pix;
                held_pix <= pix_sel;
            end
            default: raw_data <= row_cnt;
        endcase
    end

endmodule

// ==== verif/camera_front_props.sv ====
`timescale 1ns/100ps

module camera_front_props (
    input logic                          clk,
    input logic                          resetb,
    input pixel_stream_pkg::stream_tag_t raw_tag,
    input pixel_stream_pkg::stream_tag_t out_tag,
    input logic [15:0]                   filter_count
);
    import pixel_stream_pkg::*;

    logic after_row_end; // High from a row end output until the next row start output

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            after_row_end <= 1'b0;
        end else if (out_tag.dv && out_tag.wtype == wt_row_end) begin
            after_row_end <= 1'b1;
        end else if (out_tag.dv && out_tag.wtype == wt_row_start) begin
            after_row_end <= 1'b0;
        end
    end

    // No valid word on the first cycle out of reset
    assert property (@(posedge clk) $rose(resetb) |-> !out_tag.dv)
        else $error("out_tag dv is high right after reset");

    assert property (@(posedge clk) disable iff (!resetb)
        (out_tag.dv && out_tag.wtype == wt_pixel) |-> !after_row_end)
        else $error("pixel output after a row end without a row start");

    // The count is only latched by a frame end word
    assert property (@(posedge clk) disable iff (!resetb)
        !$stable(filter_count) |-> $past(raw_tag.dv && raw_tag.wtype == wt_frame_end))
        else $error("filter_count changed without a frame end input");

endmodule

bind defect_filter camera_front_props props0 (
    .clk          (clk),
    .resetb       (resetb),
    .raw_tag      (raw_tag),
    .out_tag      (out_tag),
    .filter_count (filter_count)
);

// ==== verif/camera_front_tb.sv ====
`timescale 1ns/100ps

module camera_front_tb;
    import pixel_stream_pkg::*;

    localparam int data_width = pixel_width_default;

    logic                         clk;
    logic                         resetb;
    logic                         fv;
    logic                         lv;
    logic [data_width-1:0]        pix;
    logic                         test_en;
    logic [data_width-1:0]        test_data;
    logic                         en;
    logic signed [data_width-1:0] threshold_upper;
    logic signed [data_width-1:0] threshold_lower;
    stream_tag_t                  out_tag;
    logic [data_width-1:0]        out_data;
    logic [15:0]                  filter_count;

    logic [15:0]           testdata [512];
    word_type_t            got_type [$];
    logic [data_width-1:0] got_data [$];
    word_type_t            exp_type [$];
    logic [data_width-1:0] exp_data [$];
    logic [15:0]           got_count;
    int                    frames_seen = 0;
    int                    watchdog_cycles = 0;
    int                    check_errors = 0;

    camera_front_top #(.data_width(data_width)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Outputs change on the rising edge, so they are collected half a cycle later
    always @(negedge clk) begin
        if (resetb && out_tag.dv) begin
            got_type.push_back(out_tag.wtype);
            got_data.push_back(out_data);
            if (out_tag.wtype == wt_frame_end) begin
                got_count = filter_count; // Latched on the same edge as the frame end word
                frames_seen++;
            end
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic compare_tag(input word_type_t got, input word_type_t exp, input int pos);
        if (got !== exp) begin
            $display("FAIL %0t: word %0d has type %s, expected %s", $time, pos, got.name(),
                     exp.name());
            check_errors++;
        end
    endtask

    task automatic compare_pixel(input logic [data_width-1:0] got,
                                 input logic [data_width-1:0] exp, input int pos);
        if (got !== exp) begin
            $display("FAIL %0t: word %0d has data %h, expected %h", $time, pos, got, exp);
            check_errors++;
        end
    endtask

    task automatic compare_count(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: filter_count is %0d, expected %0d", $time, got, exp);
            check_errors++;
        end
    endtask

    function automatic void expect_word(input word_type_t wtype, input logic [data_width-1:0] data);
        exp_type.push_back(wtype);
        exp_data.push_back(data);
    endfunction

    // Walks the test headers to size the watchdog
    function automatic int total_rows();
        int idx;
        int rows;
        int t;
        int r;
        idx = 1;
        total_rows = 0;
        for (t = 0; t < int'(testdata[0]); t++) begin
            rows = testdata[idx];
            idx += 7;
            total_rows += rows;
            for (r = 0; r < rows; r++) idx += 1 + 2 * int'(testdata[idx]);
        end
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic drive_row(input int npix, input int base);
        int i;
        for (i = 0; i < npix; i++) begin
            @(posedge clk);
            lv  <= 1'b1;
            pix <= testdata[base + i][data_width-1:0];
        end
        @(posedge clk);
        lv  <= 1'b0;
        pix <= '0;
    endtask

    task automatic check_frame(input int t, input logic [15:0] exp_count);
        int n;
        int i;
        n = got_type.size();
        if (n != exp_type.size()) begin
            $display("Test %0d gave %0d output words where %0d were expected", t, n,
                     exp_type.size());
            check_errors++;
            if (exp_type.size() < n) n = exp_type.size();
        end
        for (i = 0; i < n; i++) begin
            compare_tag(got_type[i], exp_type[i], i);
            compare_pixel(got_data[i], exp_data[i], i);
        end
        compare_count(got_count, exp_count);
        got_type.delete();
        got_data.delete();
        exp_type.delete();
        exp_data.delete();
    endtask

    initial begin
        int          idx;
        int          ntests;
        int          rows;
        int          npix;
        int          t;
        int          r;
        int          i;
        int          failed_tests;
        int          errors_before;
        logic [15:0] exp_count;
        void'($urandom(32'h12e0_b0f0));
        resetb          <= 1'b0;
        fv              <= 1'b0;
        lv              <= 1'b0;
        pix             <= '0;
        test_en         <= 1'b0;
        test_data       <= '0;
        en              <= 1'b0;
        threshold_upper <= '0;
        threshold_lower <= '0;
        failed_tests = 0;
        $readmemh("verif/camera_front_testdata.txt", testdata);
        ntests = testdata[0];
        if (ntests == 0) begin
            $display("The test data file holds no tests");
            check_errors++;
        end
        watchdog_cycles = 60 * total_rows() + 200 * ntests + 10;
        repeat (3) @(posedge clk);
        resetb <= 1'b1;
        idx = 1;
        for (t = 0; t < ntests; t++) begin
            errors_before = check_errors;
            rows = testdata[idx];
            @(posedge clk);
            en              <= testdata[idx + 1][0];
            threshold_upper <= testdata[idx + 2][data_width-1:0];
            threshold_lower <= testdata[idx + 3][data_width-1:0];
            test_en         <= testdata[idx + 4][0];
            test_data       <= testdata[idx + 5][data_width-1:0];
            exp_count = testdata[idx + 6];
            idx += 7;
            expect_word(wt_frame_start, data_width'(t)); // Frame number counts from reset
            idle_cycles(2);
            @(posedge clk);
            fv <= 1'b1;
            idle_cycles(2);
            for (r = 0; r < rows; r++) begin
                npix = testdata[idx];
                drive_row(npix, idx + 1);
                expect_word(wt_row_start, data_width'(r));
                for (i = 0; i < npix; i++) expect_word(wt_pixel, testdata[idx + 1 + npix + i]);
                expect_word(wt_row_end, data_width'(r));
                idx += 1 + 2 * npix;
                idle_cycles(2 + int'($urandom % 4));
            end
            @(posedge clk);
            fv <= 1'b0;
            expect_word(wt_frame_end, data_width'(rows));
            wait (frames_seen == t + 1);
            check_frame(t, exp_count);
            if (check_errors != errors_before) failed_tests++;
            $display("Test %0d done, %0d rows, %0d errors", t, rows, check_errors - errors_before);
        end
        $display("Tests run %0d, failed %0d, check errors %0d", ntests, failed_tests, check_errors);
        if (check_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verif/camera_front_testdata.txt ====
// First word: number of tests. Test line: rows en thr_up thr_lo test_en test_data count
// Row line: pixel count, then the sensor pixels, then the expected output pixels

5

// Test 0: one hot pixel with uneven neighbours, hot pixels on the row edges
0002 1 0020 0020 0 0000 0001
5 0100 0101 0400 0104 0100
  0100 0101 0102 0104 0100
4 0900 0200 0200 0900
  0900 0200 0200 0900

// Test 1: dead pixel, one-sided outliers and values at the threshold
0003 1 0040 0030 0 0000 0002
6 0300 0300 0200 0300 0380 0400
  0300 0300 0300 0300 0380 0400
5 0500 0540 0500 04d0 0500
  0500 0540 0500 04d0 0500
3 0500 0541 0500
  0500 0500 0500

// Test 2: filter disabled, defects are still counted
0002 0 0020 0020 0 0000 0002
5 0100 0400 0100 0010 0100
  0100 0400 0100 0010 0100
3 0100 0100 0100
  0100 0100 0100

// Test 3: test pattern replaces every pixel
0002 1 0010 0010 1 0abc 0000
4 0100 0900 0100 0100
  0abc 0abc 0abc 0abc
3 0100 0000 0100
  0abc 0abc 0abc

// Test 4: count holds only this frame's defect
0001 1 0020 0020 0 0000 0001
4 0100 0100 0800 0100
  0100 0100 0100 0100

// ==== verilog.f ====
logic/pixel_stream_pkg.sv
logic/stream_framer.sv
logic/defect_filter.sv
logic/camera_front_top.sv
verif/camera_front_props.sv
verif/camera_front_tb.sv
